/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = cpuTb
FILELIST = compile.f

SRCS = $(shell cat $(FILELIST))
BIN  = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

/* bench/cpuAssert.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuAssert (
    input logic       clk,
    input logic       rstN,
    input logic       extAck,
    input logic       fetchAck,
    input logic       dataAck,
    input logic       ramAck,
    input logic       ramStb,
    input logic       extCyc,
    input logic       fetchCyc,
    input logic       dataCyc,
    input logic [2:0] grant
);

    oneAckPerCycle: assert property (@(posedge clk) disable iff (!rstN)
        $onehot0({extAck, fetchAck, dataAck}))
        else $error("more than one master acknowledged in a cycle");

    ackAfterStb: assert property (@(posedge clk) disable iff (!rstN)
        ramAck |-> $past(ramStb))
        else $error("RAM acknowledged without a preceding strobe");

    // Owner keeps the bus while its cycle is open
    grantHeld: assert property (@(posedge clk) disable iff (!rstN)
        (|(grant & {dataCyc, fetchCyc, extCyc})) |=> (grant == $past(grant)))
        else $error("grant changed while the granted master held cyc");

    ackSingleCycle: assert property (@(posedge clk) disable iff (!rstN)
        ramAck |=> !ramAck)
        else $error("acknowledge lasted longer than one cycle");

endmodule

bind busArbiter cpuAssert cpuAssertInst (.*);

`default_nettype wire

/* bench/cpuTb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuTb;

    localparam int cycleLimit = 4000;       // Load, run and readback of both programs
    localparam logic [15:0] resBase = 16'h0200;
    localparam logic [15:0] memBase = 16'h0300;

    logic clk = 1'b0;
    logic rstN, run, halted, err;
    logic extCyc, extStb, extWe, extAck;
    logic [15:0] extAdr, extDatW, extDatR;

    logic [15:0] prog[$];
    logic [15:0] expVals[$];
    logic [15:0] opA, opB, haltSlot, rdVal;
    int seed;
    int cycles = 0;

    cpuTop #(.memAddrBits(10)) cpuTop_inst (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("Finished with errors");
            $fatal(1);
        end
    end

    function automatic logic [15:0] encI(cpuPkg::opcodeT op, logic [2:0] rs, logic [2:0] rd,
                                         logic [4:0] imm);
        return {op, rs, rd, imm};
    endfunction

    function automatic logic [15:0] encR(cpuPkg::opcodeT op, logic [2:0] rs, logic [2:0] rt,
                                         logic [2:0] rd, logic [1:0] fn);
        return {op, rs, rt, rd, fn};
    endfunction

    function automatic logic [15:0] enc8(cpuPkg::opcodeT op, logic [2:0] rs, logic [7:0] imm);
        return {op, rs, imm};
    endfunction

    function automatic logic [15:0] rotl(logic [15:0] x, logic [3:0] n);
        logic [31:0] t;
        t = {x, x} << n;
        return t[31:16];
    endfunction

    function automatic logic [15:0] rotr(logic [15:0] x, logic [3:0] n);
        logic [31:0] t;
        t = {x, x} >> n;
        return t[15:0];
    endfunction

    // Kinds 0..7 follow add, sub, xor, andn, rol, sll, ror, srl
    function automatic logic [15:0] refOp(int kind, logic [15:0] x, logic [15:0] y);
        case (kind)
            0: return x + y;
            1: return y - x;  // Operand minus rs
            2: return x ^ y;
            3: return x & ~y;
            4: return rotl(x, y[3:0]);
            5: return x << y[3:0];
            6: return rotr(x, y[3:0]);
            7: return x >> y[3:0];
            default: return 16'h0000;
        endcase
    endfunction

    function automatic logic [15:0] fillWord(logic [15:0] adr);
        return (adr * 16'd3) ^ 16'hA5C3;
    endfunction

    function automatic logic [15:0] pcNow();
        return 16'(2 * prog.size());
    endfunction

    task automatic emit(input logic [15:0] word);
        prog.push_back(word);
    endtask

    task automatic storeResult(input logic [2:0] r, input logic [15:0] expVal);
        emit(encI(cpuPkg::OP_STU, 3'd6, r, 5'd2));  // Store to the next slot as the base advances
        expVals.push_back(expVal);
    endtask

    task automatic loadConst(input logic [2:0] r, input logic [15:0] v);
        emit(enc8(cpuPkg::OP_LBI, r, v[15:8]));
        emit(enc8(cpuPkg::OP_SLBI, r, v[7:0]));
    endtask

    task automatic checkWord(input string name, input logic [15:0] expVal,
                             input logic [15:0] actVal);
        assert (actVal === expVal) else begin
            $display("Error: %s expected %h, got %h", name, expVal, actVal);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    task automatic extWrite(input logic [15:0] adr, input logic [15:0] dat);
        @(negedge clk);
        extCyc  = 1'b1;
        extStb  = 1'b1;
        extWe   = 1'b1;
        extAdr  = adr;
        extDatW = dat;
        do @(negedge clk); while (!extAck);
        @(negedge clk);  // Ack edge has passed
        extCyc = 1'b0;
        extStb = 1'b0;
        extWe  = 1'b0;
    endtask

    task automatic extRead(input logic [15:0] adr, output logic [15:0] dat);
        @(negedge clk);
        extCyc = 1'b1;
        extStb = 1'b1;
        extWe  = 1'b0;
        extAdr = adr;
        do @(negedge clk); while (!extAck);
        dat = extDatR;
        @(negedge clk);
        extCyc = 1'b0;
        extStb = 1'b0;
    endtask

    task automatic buildProgram();
        cpuPkg::opcodeT iOps[8];
        cpuPkg::opcodeT brOps[4];
        logic [31:0] rnd;
        logic [4:0] imm;
        logic [15:0] operand, val, p;
        logic taken;
        iOps = '{cpuPkg::OP_ADDI, cpuPkg::OP_SUBI, cpuPkg::OP_XORI, cpuPkg::OP_ANDNI,
                 cpuPkg::OP_ROLI, cpuPkg::OP_SLLI, cpuPkg::OP_RORI, cpuPkg::OP_SRLI};
        brOps = '{cpuPkg::OP_BEQZ, cpuPkg::OP_BNEZ, cpuPkg::OP_BLTZ, cpuPkg::OP_BGEZ};
        rnd = $random(seed);
        opA = rnd[15:0];
        rnd = $random(seed);
        opB = rnd[15:0];
        loadConst(3'd6, resBase);
        loadConst(3'd1, opA);
        loadConst(3'd2, opB);
        loadConst(3'd5, memBase);
        for (int k = 0; k < 8; k++) begin
            rnd = $random(seed);
            imm = rnd[4:0];
            operand = (k < 2) ? {{11{imm[4]}}, imm} : {11'b0, imm};  // ADDI, SUBI sign extend
            emit(encI(iOps[k], 3'd1, 3'd3, imm));
            storeResult(3'd3, refOp(k, opA, operand));
        end
        for (int k = 0; k < 8; k++) begin
            emit(encR(k < 4 ? cpuPkg::OP_RTYPE : cpuPkg::OP_SHIFT, 3'd1, 3'd2, 3'd3, 2'(k)));
            storeResult(3'd3, refOp(k, opA, opB));
        end
        emit(encR(cpuPkg::OP_SEQ, 3'd1, 3'd2, 3'd3, 2'd0));
        storeResult(3'd3, {15'b0, opA == opB});
        emit(encR(cpuPkg::OP_SEQ, 3'd1, 3'd1, 3'd3, 2'd0));
        storeResult(3'd3, 16'd1);
        emit(encR(cpuPkg::OP_SLT, 3'd1, 3'd2, 3'd3, 2'd0));
        storeResult(3'd3, {15'b0, $signed(opA) < $signed(opB)});
        emit(encR(cpuPkg::OP_SLT, 3'd2, 3'd1, 3'd3, 2'd0));
        storeResult(3'd3, {15'b0, $signed(opB) < $signed(opA)});
        emit(encR(cpuPkg::OP_SLE, 3'd1, 3'd2, 3'd3, 2'd0));
        storeResult(3'd3, {15'b0, $signed(opA) <= $signed(opB)});
        emit(encR(cpuPkg::OP_SLE, 3'd1, 3'd1, 3'd3, 2'd0));
        storeResult(3'd3, 16'd1);
        emit(encI(cpuPkg::OP_ST, 3'd5, 3'd1, 5'd0));  // Store then load back
        emit(encI(cpuPkg::OP_LD, 3'd5, 3'd4, 5'd0));
        storeResult(3'd4, opA);
        for (int k = 0; k < 2; k++) begin
            storeResult(3'd6, resBase + 16'(2 * expVals.size()));  // Old base value
        end
        emit(enc8(cpuPkg::OP_LBI, 3'd4, 8'hFF));  // r4 negative, r0 zero
        for (int k = 0; k < 8; k++) begin
            val = (k % 2 == 0) ? 16'h0000 : 16'hFFFF;
            case (k / 2)
                0: taken = (val == 16'h0000);
                1: taken = (val != 16'h0000);
                2: taken = val[15];
                default: taken = !val[15];
            endcase
            emit(enc8(cpuPkg::OP_LBI, 3'd3, 8'd1));
            emit(enc8(brOps[k / 2], (k % 2 == 0) ? 3'd0 : 3'd4, 8'd2));
            emit(enc8(cpuPkg::OP_LBI, 3'd3, 8'd0));  // Skipped when taken
            storeResult(3'd3, taken ? 16'd1 : 16'd0);
        end
        emit(enc8(cpuPkg::OP_LBI, 3'd3, 8'd1));
        emit({cpuPkg::OP_J, 11'd2});
        emit(enc8(cpuPkg::OP_LBI, 3'd3, 8'd0));
        storeResult(3'd3, 16'd1);
        emit(enc8(cpuPkg::OP_LBI, 3'd3, 8'd1));
        p = pcNow();
        emit({cpuPkg::OP_JAL, 11'd2});
        emit(enc8(cpuPkg::OP_LBI, 3'd3, 8'd0));
        storeResult(3'd3, 16'd1);
        storeResult(3'd7, p + 16'd2);
        p = pcNow();
        loadConst(3'd5, p + 16'd10);  // Target is the STU below
        emit(enc8(cpuPkg::OP_LBI, 3'd3, 8'd1));
        emit(enc8(cpuPkg::OP_JR, 3'd5, 8'd0));
        emit(enc8(cpuPkg::OP_LBI, 3'd3, 8'd0));
        storeResult(3'd3, 16'd1);
        p = pcNow();
        loadConst(3'd5, p + 16'd10);
        emit(enc8(cpuPkg::OP_LBI, 3'd3, 8'd1));
        emit(enc8(cpuPkg::OP_JALR, 3'd5, 8'd0));
        emit(enc8(cpuPkg::OP_LBI, 3'd3, 8'd0));
        storeResult(3'd3, 16'd1);
        storeResult(3'd7, p + 16'd8);
        emit(16'h0000);  // HALT
        emit(enc8(cpuPkg::OP_LBI, 3'd3, 8'h77));
        emit(encI(cpuPkg::OP_STU, 3'd6, 3'd3, 5'd2));  // Must never run
        haltSlot = resBase + 16'(2 * (expVals.size() + 1));
    endtask

    task automatic resetDut();
        rstN = 1'b0;
        repeat (16) @(negedge clk);
        rstN = 1'b1;
    endtask

    initial begin
        int k;
        run     = 1'b0;
        extCyc  = 1'b0;
        extStb  = 1'b0;
        extWe   = 1'b0;
        extAdr  = '0;
        extDatW = '0;
        seed    = 32'hcb30_a856;
        resetDut();
        buildProgram();
        for (int i = 0; i < prog.size(); i++) extWrite(16'(2 * i), prog[i]);
        for (int i = 0; i < 64; i++) begin
            extWrite(resBase + 16'(2 * i), fillWord(resBase + 16'(2 * i)));
        end
        @(negedge clk);
        run = 1'b1;
        k = 0;
        while (!halted) begin  // Ext reads compete with the running core
            extRead(16'(2 * k), rdVal);
            checkWord($sformatf("extDatR at %h", 16'(2 * k)), prog[k], rdVal);
            k = (k + 1) % prog.size();
            repeat (10) @(negedge clk);
        end
        checkWord("err", 16'd0, {15'b0, err});
        run = 1'b0;
        for (int i = 0; i < expVals.size(); i++) begin
            extRead(resBase + 16'(2 * (i + 1)), rdVal);
            checkWord($sformatf("result word %0d", i), expVals[i], rdVal);
        end
        extRead(haltSlot, rdVal);
        checkWord("word after HALT", fillWord(haltSlot), rdVal);
        extRead(memBase, rdVal);
        checkWord("ST data word", opA, rdVal);
        checkWord("halted", 16'd1, {15'b0, halted});  // Still halted after the readback

        resetDut();  // Second program with one illegal opcode
        extWrite(16'h0000, {5'b00010, 11'd0});
        @(negedge clk);
        run = 1'b1;
        while (!halted) @(negedge clk);
        checkWord("err", 16'd1, {15'b0, err});
        extRead(16'h0000, rdVal);
        checkWord("illegal instruction word", {5'b00010, 11'd0}, rdVal);
        checkWord("halted", 16'd1, {15'b0, halted});
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
hdl/cpuPkg.sv
hdl/control.sv
hdl/regFile.sv
hdl/alu.sv
hdl/execCore.sv
hdl/fetchUnit.sv
hdl/memAccess.sv
hdl/busArbiter.sv
hdl/wbRam.sv
hdl/cpuTop.sv
bench/cpuAssert.sv
bench/cpuTb.sv

/* hdl/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic [cpuPkg::dataWidth-1:0] a,
    input  logic [cpuPkg::dataWidth-1:0] b,
    input  cpuPkg::aluOpT                op,
    output logic [cpuPkg::dataWidth-1:0] result
);

    logic [3:0] shAmt;
    logic [4:0] rotBack;

    assign shAmt   = b[3:0];
    assign rotBack = 5'd16 - {1'b0, shAmt};  // 16 for a zero shift, giving no wrap bits

    always_comb begin
        case (op)
            cpuPkg::ADD:   result = a + b;
            cpuPkg::SUB:   result = b - a;  // WISC order, operand minus rs
            cpuPkg::XOR:   result = a ^ b;
            cpuPkg::ANDN:  result = a & ~b;
            cpuPkg::ROL:   result = (a << shAmt) | (a >> rotBack);
            cpuPkg::SLL:   result = a << shAmt;
            cpuPkg::ROR:   result = (a >> shAmt) | (a << rotBack);
            cpuPkg::SRL:   result = a >> shAmt;
            cpuPkg::SEQ:   result = {15'b0, a == b};
            cpuPkg::SLT:   result = {15'b0, $signed(a) < $signed(b)};
            cpuPkg::SLE:   result = {15'b0, $signed(a) <= $signed(b)};
            cpuPkg::PASSB: result = b;
            cpuPkg::SLBI:  result = {a[7:0], b[7:0]};
            default:       result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/busArbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module busArbiter (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         extCyc,
    input  logic                         extStb,
    input  logic                         extWe,
    input  logic [cpuPkg::dataWidth-1:0] extAdr,
    input  logic [cpuPkg::dataWidth-1:0] extDatW,
    output logic                         extAck,
    output logic [cpuPkg::dataWidth-1:0] extDatR,
    input  logic                         fetchCyc,
    input  logic                         fetchStb,
    input  logic [cpuPkg::dataWidth-1:0] fetchAdr,
    output logic                         fetchAck,
    output logic [cpuPkg::dataWidth-1:0] fetchDatR,
    input  logic                         dataCyc,
    input  logic                         dataStb,
    input  logic                         dataWe,
    input  logic [cpuPkg::dataWidth-1:0] dataAdr,
    input  logic [cpuPkg::dataWidth-1:0] dataDatW,
    output logic                         dataAck,
    output logic [cpuPkg::dataWidth-1:0] dataDatR,
    output logic                         ramCyc,
    output logic                         ramStb,
    output logic                         ramWe,
    output logic [cpuPkg::dataWidth-1:0] ramAdr,
    output logic [cpuPkg::dataWidth-1:0] ramDatW,
    input  logic                         ramAck,
    input  logic [cpuPkg::dataWidth-1:0] ramDatR
);

    logic [2:0] grant;  // One-hot, bit 0 ext, bit 1 fetch, bit 2 data

    always_ff @(posedge clk) begin
        if (!rstN) begin
            grant <= 3'b000;
        end else if (grant == 3'b000) begin
            if (extCyc) grant <= 3'b001;
            else if (fetchCyc) grant <= 3'b010;
            else if (dataCyc) grant <= 3'b100;
        end else if ((grant & {dataCyc, fetchCyc, extCyc}) == 3'b000) begin
            grant <= 3'b000;  // Owner dropped cyc
        end
    end

    assign ramCyc  = |(grant & {dataCyc, fetchCyc, extCyc});
    assign ramStb  = |(grant & {dataStb, fetchStb, extStb});
    assign ramWe   = (grant[0] && extWe) || (grant[2] && dataWe);
    assign ramAdr  = grant[0] ? extAdr : grant[1] ? fetchAdr : grant[2] ? dataAdr : '0;
    assign ramDatW = grant[0] ? extDatW : grant[2] ? dataDatW : '0;

    assign extAck    = grant[0] && ramAck;
    assign fetchAck  = grant[1] && ramAck;
    assign dataAck   = grant[2] && ramAck;
    assign extDatR   = grant[0] ? ramDatR : '0;
    assign fetchDatR = grant[1] ? ramDatR : '0;
    assign dataDatR  = grant[2] ? ramDatR : '0;

endmodule

`default_nettype wire

/* hdl/control.sv */
`timescale 1ns/1ps
`default_nettype none

module control (
    input  logic [cpuPkg::dataWidth-1:0] instr,
    output logic                         haltSig,
    output logic                         regWrt,
    output logic                         zeroExt,
    output logic                         memRead,
    output logic                         memWrt,
    output logic                         immSrc,      // Branch offset is the 8-bit immediate
    output logic                         aluJmp,      // Jump target comes from the ALU
    output logic                         err,
    output cpuPkg::aluOpT                aluOp,
    output cpuPkg::regSrcT               regSrc,
    output cpuPkg::bSrcT                 bSrc,
    output logic [1:0]                   regDst,      // 00 rd I1, 01 rs, 10 rd R, 11 r7
    output logic [2:0]                   branchKind   // 000 none, 001 always, 1cc conditional
);

    cpuPkg::opcodeT opcode;

    assign opcode = cpuPkg::opcodeT'(instr[15:11]);

    always_comb begin
        haltSig    = 1'b0;
        regWrt     = 1'b0;
        zeroExt    = 1'b0;
        memRead    = 1'b0;
        memWrt     = 1'b0;
        immSrc     = 1'b0;
        aluJmp     = 1'b0;
        err        = 1'b0;
        aluOp      = cpuPkg::ADD;
        regSrc     = cpuPkg::SRC_ALU;
        bSrc       = cpuPkg::B_REG;
        regDst     = 2'b00;
        branchKind = 3'b000;

        case (opcode)
            cpuPkg::OP_HALT: haltSig = 1'b1;
            cpuPkg::OP_NOP:  regWrt = 1'b0;  // Nothing changes
            cpuPkg::OP_ADDI, cpuPkg::OP_SUBI, cpuPkg::OP_XORI, cpuPkg::OP_ANDNI: begin
                regWrt  = 1'b1;
                bSrc    = cpuPkg::B_IMM5;
                zeroExt = instr[12];  // XORI and ANDNI zero extend
                aluOp   = cpuPkg::aluOpT'({2'b00, instr[12:11]});
            end
            cpuPkg::OP_ROLI, cpuPkg::OP_SLLI, cpuPkg::OP_RORI, cpuPkg::OP_SRLI: begin
                regWrt  = 1'b1;
                bSrc    = cpuPkg::B_IMM5;
                zeroExt = 1'b1;
                aluOp   = cpuPkg::aluOpT'({2'b01, instr[12:11]});
            end
            cpuPkg::OP_ST: begin
                memWrt = 1'b1;
                bSrc   = cpuPkg::B_IMM5;  // Address is rs plus offset
            end
            cpuPkg::OP_LD: begin
                memRead = 1'b1;
                regWrt  = 1'b1;
                regSrc  = cpuPkg::SRC_MEM;
                bSrc    = cpuPkg::B_IMM5;
            end
            cpuPkg::OP_STU: begin
                memWrt = 1'b1;
                regWrt = 1'b1;
                regDst = 2'b01;  // Updated address back to rs
                bSrc   = cpuPkg::B_IMM5;
            end
            cpuPkg::OP_RTYPE, cpuPkg::OP_SHIFT: begin
                regWrt = 1'b1;
                regDst = 2'b10;
                aluOp  = cpuPkg::aluOpT'({1'b0, ~instr[11], instr[1:0]});
            end
            cpuPkg::OP_SEQ, cpuPkg::OP_SLT, cpuPkg::OP_SLE: begin
                regWrt = 1'b1;
                regDst = 2'b10;
                regSrc = cpuPkg::SRC_CMP;
                aluOp  = cpuPkg::aluOpT'({2'b10, instr[12:11]});
            end
            cpuPkg::OP_BEQZ, cpuPkg::OP_BNEZ, cpuPkg::OP_BLTZ, cpuPkg::OP_BGEZ: begin
                immSrc     = 1'b1;
                bSrc       = cpuPkg::B_IMM8;
                branchKind = {1'b1, instr[12:11]};
            end
            cpuPkg::OP_LBI: begin
                regWrt = 1'b1;
                regDst = 2'b01;
                bSrc   = cpuPkg::B_IMM8;
                aluOp  = cpuPkg::PASSB;
            end
            cpuPkg::OP_SLBI: begin
                regWrt  = 1'b1;
                regDst  = 2'b01;
                zeroExt = 1'b1;
                bSrc    = cpuPkg::B_IMM8;
                aluOp   = cpuPkg::SLBI;
            end
            cpuPkg::OP_J, cpuPkg::OP_JAL: begin
                regWrt     = instr[12];  // Link only for JAL
                regDst     = 2'b11;
                regSrc     = cpuPkg::SRC_PC2;
                bSrc       = cpuPkg::B_DISP;
                branchKind = 3'b001;
            end
            cpuPkg::OP_JR, cpuPkg::OP_JALR: begin
                regWrt     = instr[12];
                regDst     = 2'b11;
                regSrc     = cpuPkg::SRC_PC2;
                aluJmp     = 1'b1;  // rs plus imm8 from the ALU
                bSrc       = cpuPkg::B_IMM8;
                branchKind = 3'b001;
            end
            default: err = 1'b1;  // Unsupported opcode
        endcase
    end

endmodule

`default_nettype wire

/* hdl/cpuPkg.sv */
`default_nettype none

package cpuPkg;

    localparam int dataWidth   = 16;
    localparam int regAddrBits = 3;  // Eight registers

    // Instruction bits 15..11
    typedef enum logic [4:0] {
        OP_HALT  = 5'b00000, OP_NOP   = 5'b00001,
        OP_J     = 5'b00100, OP_JR    = 5'b00101, OP_JAL  = 5'b00110, OP_JALR = 5'b00111,
        OP_ADDI  = 5'b01000, OP_SUBI  = 5'b01001, OP_XORI = 5'b01010, OP_ANDNI = 5'b01011,
        OP_BEQZ  = 5'b01100, OP_BNEZ  = 5'b01101, OP_BLTZ = 5'b01110, OP_BGEZ = 5'b01111,
        OP_ST    = 5'b10000, OP_LD    = 5'b10001, OP_SLBI = 5'b10010, OP_STU  = 5'b10011,
        OP_ROLI  = 5'b10100, OP_SLLI  = 5'b10101, OP_RORI = 5'b10110, OP_SRLI = 5'b10111,
        OP_LBI   = 5'b11000, OP_SHIFT = 5'b11010, OP_RTYPE = 5'b11011,
        OP_SEQ   = 5'b11100, OP_SLT   = 5'b11101, OP_SLE  = 5'b11110
    } opcodeT;

    // Order matters, the decoder builds the low bits from the instruction
    typedef enum logic [3:0] {
        ADD, SUB, XOR, ANDN,
        ROL, SLL, ROR, SRL,
        SEQ, SLT, SLE, PASSB,
        SLBI
    } aluOpT;

    typedef enum logic [2:0] {IDLE, FETCH, EXEC, MEM, WB, HALTED} coreStateT;

    typedef enum logic [1:0] {SRC_PC2, SRC_MEM, SRC_ALU, SRC_CMP} regSrcT;

    typedef enum logic [1:0] {B_REG, B_IMM5, B_IMM8, B_DISP} bSrcT;

endpackage

`default_nettype wire

/* hdl/cpuTop.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuTop #(
    parameter int memAddrBits = 10
) (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         run,
    output logic                         halted,
    output logic                         err,
    input  logic                         extCyc,
    input  logic                         extStb,
    input  logic                         extWe,
    input  logic [cpuPkg::dataWidth-1:0] extAdr,
    input  logic [cpuPkg::dataWidth-1:0] extDatW,
    output logic                         extAck,
    output logic [cpuPkg::dataWidth-1:0] extDatR
);

    // Core to bus masters
    logic fetchReq, fetchDone, memReq, memWe, memDone;
    logic [cpuPkg::dataWidth-1:0] fetchAddr, instr, memAddr, memWData, memRData;

    // Masters to arbiter
    logic fetchCyc, fetchStb, fetchAck;
    logic [cpuPkg::dataWidth-1:0] fetchAdr, fetchDatR;
    logic dataCyc, dataStb, dataWe, dataAck;
    logic [cpuPkg::dataWidth-1:0] dataAdr, dataDatW, dataDatR;

    // Arbiter to RAM
    logic ramCyc, ramStb, ramWe, ramAck;
    logic [cpuPkg::dataWidth-1:0] ramAdr, ramDatW, ramDatR;

    execCore execCoreInst (.*);

    fetchUnit fetchUnitInst (.*);

    memAccess memAccessInst (.*);

    busArbiter busArbiterInst (.*);

    wbRam #(
        .memAddrBits(memAddrBits)
    ) wbRamInst (.*);

endmodule

`default_nettype wire

/* hdl/execCore.sv */
`timescale 1ns/1ps
`default_nettype none

module execCore (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         run,
    output logic                         halted,
    output logic                         err,
    output logic                         fetchReq,
    output logic [cpuPkg::dataWidth-1:0] fetchAddr,
    input  logic                         fetchDone,
    input  logic [cpuPkg::dataWidth-1:0] instr,
    output logic                         memReq,
    output logic                         memWe,
    output logic [cpuPkg::dataWidth-1:0] memAddr,
    output logic [cpuPkg::dataWidth-1:0] memWData,
    input  logic                         memDone,
    input  logic [cpuPkg::dataWidth-1:0] memRData
);

    cpuPkg::coreStateT state;
    cpuPkg::aluOpT     aluOp;
    cpuPkg::regSrcT    regSrc;
    cpuPkg::bSrcT      bSrc;

    logic haltSig, regWrt, zeroExt, memRead, memWrt, immSrc, aluJmp, decErr, taken, wrEn;
    logic [1:0] regDst;
    logic [2:0] branchKind;
    logic [cpuPkg::regAddrBits-1:0] rdAddrA, rdAddrB, wrAddr;
    logic [cpuPkg::dataWidth-1:0] pc, ir, aluRes, memData, rdDataA, rdDataB, wrData;
    logic [cpuPkg::dataWidth-1:0] imm5, imm8, disp11, bOperand, aluOut, pcPlus2, nextPc;

    control controlInst (.instr(ir), .err(decErr), .*);
    regFile regFileInst (.*);
    alu aluInst (.a(rdDataA), .b(bOperand), .op(aluOp), .result(aluOut));

    assign rdAddrA = ir[10:8];
    assign rdAddrB = ir[7:5];  // Rt, or the store data register
    assign imm5    = zeroExt ? {11'b0, ir[4:0]} : {{11{ir[4]}}, ir[4:0]};
    assign imm8    = zeroExt ? {8'b0, ir[7:0]} : {{8{ir[7]}}, ir[7:0]};
    assign disp11  = {{5{ir[10]}}, ir[10:0]};
    assign pcPlus2 = pc + 16'd2;

    always_comb begin
        case (bSrc)
            cpuPkg::B_IMM5: bOperand = imm5;
            cpuPkg::B_IMM8: bOperand = imm8;
            cpuPkg::B_DISP: bOperand = disp11;
            default:        bOperand = rdDataB;
        endcase
        case (branchKind)
            3'b001:  taken = 1'b1;
            3'b100:  taken = (rdDataA == '0);
            3'b101:  taken = (rdDataA != '0);
            3'b110:  taken = rdDataA[15];
            3'b111:  taken = !rdDataA[15];
            default: taken = 1'b0;
        endcase
        case (regDst)
            2'b00:   wrAddr = ir[7:5];
            2'b01:   wrAddr = ir[10:8];
            2'b10:   wrAddr = ir[4:2];
            default: wrAddr = 3'd7;  // Link register
        endcase
        case (regSrc)
            cpuPkg::SRC_PC2: wrData = pcPlus2;
            cpuPkg::SRC_MEM: wrData = memData;
            cpuPkg::SRC_CMP: wrData = {15'b0, aluRes[0]};
            default:         wrData = aluRes;
        endcase
    end

    assign nextPc    = !taken ? pcPlus2 :
                       aluJmp ? aluRes : pcPlus2 + (immSrc ? imm8 : disp11);
    assign wrEn      = regWrt && (state == cpuPkg::WB);
    assign halted    = (state == cpuPkg::HALTED);
    assign fetchAddr = pc;
    assign memAddr   = aluRes;
    assign memWe     = memWrt;
    assign memWData  = rdDataB;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state    <= cpuPkg::IDLE;
            pc       <= '0;
            fetchReq <= 1'b0;
            memReq   <= 1'b0;
            err      <= 1'b0;
        end else begin
            fetchReq <= 1'b0;  // Both requests are single pulses
            memReq   <= 1'b0;
            case (state)
                cpuPkg::IDLE: begin
                    if (run) begin
                        state    <= cpuPkg::FETCH;
                        fetchReq <= 1'b1;
                    end
                end
                cpuPkg::FETCH: if (fetchDone) state <= cpuPkg::EXEC;
                cpuPkg::EXEC: begin
                    memReq <= memRead || memWrt;
                    state  <= (memRead || memWrt) ? cpuPkg::MEM : cpuPkg::WB;
                end
                cpuPkg::MEM: if (memDone) state <= cpuPkg::WB;
                cpuPkg::WB: begin
                    if (haltSig || decErr) begin
                        state <= cpuPkg::HALTED;
                        err   <= decErr;
                    end else begin
                        pc       <= nextPc;
                        fetchReq <= 1'b1;
                        state    <= cpuPkg::FETCH;
                    end
                end
                cpuPkg::HALTED: state <= cpuPkg::HALTED;  // Only reset leaves
                default: state <= cpuPkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fetchDone) ir <= instr;
        if (state == cpuPkg::EXEC) aluRes <= aluOut;
        if (memDone) memData <= memRData;
    end

endmodule

`default_nettype wire

/* hdl/fetchUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchUnit (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         fetchReq,
    input  logic [cpuPkg::dataWidth-1:0] fetchAddr,
    output logic                         fetchDone,
    output logic [cpuPkg::dataWidth-1:0] instr,
    output logic                         fetchCyc,
    output logic                         fetchStb,
    output logic [cpuPkg::dataWidth-1:0] fetchAdr,
    input  logic                         fetchAck,
    input  logic [cpuPkg::dataWidth-1:0] fetchDatR
);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            fetchCyc  <= 1'b0;
            fetchStb  <= 1'b0;
            fetchDone <= 1'b0;
        end else begin
            fetchDone <= fetchAck;  // Word is in instr on this pulse
            if (fetchReq) begin
                fetchCyc <= 1'b1;
                fetchStb <= 1'b1;
            end else if (fetchAck) begin
                fetchCyc <= 1'b0;
                fetchStb <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetchReq) fetchAdr <= fetchAddr;
        if (fetchAck) instr <= fetchDatR;
    end

endmodule

`default_nettype wire

/* hdl/memAccess.sv */
`timescale 1ns/1ps
`default_nettype none

module memAccess (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         memReq,
    input  logic                         memWe,
    input  logic [cpuPkg::dataWidth-1:0] memAddr,
    input  logic [cpuPkg::dataWidth-1:0] memWData,
    output logic                         memDone,
    output logic [cpuPkg::dataWidth-1:0] memRData,
    output logic                         dataCyc,
    output logic                         dataStb,
    output logic                         dataWe,
    output logic [cpuPkg::dataWidth-1:0] dataAdr,
    output logic [cpuPkg::dataWidth-1:0] dataDatW,
    input  logic                         dataAck,
    input  logic [cpuPkg::dataWidth-1:0] dataDatR
);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            dataCyc <= 1'b0;
            dataStb <= 1'b0;
            dataWe  <= 1'b0;
            memDone <= 1'b0;
        end else begin
            memDone <= dataAck;
            if (memReq) begin
                dataCyc <= 1'b1;
                dataStb <= 1'b1;
                dataWe  <= memWe;
            end else if (dataAck) begin
                dataCyc <= 1'b0;
                dataStb <= 1'b0;
                dataWe  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (memReq) begin
            dataAdr  <= memAddr;
            dataDatW <= memWData;
        end
        if (dataAck) memRData <= dataDatR;  // Ignored by the core on stores
    end

endmodule

`default_nettype wire

/* hdl/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic [cpuPkg::regAddrBits-1:0] rdAddrA,
    input  logic [cpuPkg::regAddrBits-1:0] rdAddrB,
    output logic [cpuPkg::dataWidth-1:0]   rdDataA,
    output logic [cpuPkg::dataWidth-1:0]   rdDataB,
    input  logic                           wrEn,
    input  logic [cpuPkg::regAddrBits-1:0] wrAddr,
    input  logic [cpuPkg::dataWidth-1:0]   wrData
);

    logic [cpuPkg::dataWidth-1:0] regs [2**cpuPkg::regAddrBits];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            regs <= '{default: '0};
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    assign rdDataA = regs[rdAddrA];  // Asynchronous reads
    assign rdDataB = regs[rdAddrB];

endmodule

`default_nettype wire

/* hdl/wbRam.sv */
`timescale 1ns/1ps
`default_nettype none

module wbRam #(
    parameter int memAddrBits = 10
) (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         ramCyc,
    input  logic                         ramStb,
    input  logic                         ramWe,
    input  logic [cpuPkg::dataWidth-1:0] ramAdr,
    input  logic [cpuPkg::dataWidth-1:0] ramDatW,
    output logic                         ramAck,
    output logic [cpuPkg::dataWidth-1:0] ramDatR
);

    logic [cpuPkg::dataWidth-1:0] mem [2**memAddrBits];
    logic access;

    assign access = ramCyc && ramStb && !ramAck;  // New request, not the held one

    always_ff @(posedge clk) begin
        if (!rstN) ramAck <= 1'b0;
        else ramAck <= access;
    end

    always_ff @(posedge clk) begin
        if (access) begin
            if (ramWe) mem[ramAdr[memAddrBits:1]] <= ramDatW;
            ramDatR <= mem[ramAdr[memAddrBits:1]];
        end
    end

endmodule

`default_nettype wire
